/* sim.f */
src/bus_pkg.sv
src/crypto_pkg.sv
src/cmd_decode.sv
src/addr_gen.sv
src/duplex_core.sv
src/wrap_sequencer.sv
src/result_unit.sv
src/crypto_top.sv
sim/crypto_checker.sv
sim/tb_monitor.sv
sim/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sim.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_top.sv */
module tb_top
    import bus_pkg::*, crypto_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [63:0] MASTER_KEY  = 64'h0f1e_2d3c_4b5a_6978;
    localparam int          CMD_CREDITS = 1;
    localparam int          TIMEOUT     = 2000;
    localparam addr_t       KEY_BASE    = 16'h0100;
    localparam addr_t       AD_BASE     = 16'h1000;
    localparam addr_t       BODY_BASE   = 16'h2000;
    localparam addr_t       OUT_BASE    = 16'h3000;
    localparam addr_t       TAG_BASE    = 16'h4000;
    localparam addr_t       PLAIN_BASE  = 16'h5000;

    logic     clk;
    logic     reset;
    logic     cmd_valid;
    cmd_t     cmd;
    word_t    mem_rdata = '0;
    mem_req_t mem_req;
    result_t  result;
    logic     credit_return;
    logic     pre_we;
    addr_t    pre_addr;
    word_t    pre_data;
    addr_t    ann_plain;
    int       credits;
    int       issued;
    bit       timed_out;
    int       tests_run;
    int       tests_failed;
    word_t    mem [0:32767];

    always #10 clk = ~clk;

    // one-cycle read latency
    always @(posedge clk)
    begin
        if (pre_we)
            mem[pre_addr[15:1]] <= pre_data;
        if (mem_req.en && mem_req.wr)
            mem[mem_req.addr[15:1]] <= mem_req.wdata;
        else if (mem_req.en)
            mem_rdata <= mem[mem_req.addr[15:1]];
    end

    always @(posedge clk)
    begin
        if (reset)
            credits <= CMD_CREDITS;
        else
            credits <= credits + int'(credit_return) - int'(cmd_valid);
    end

    crypto_top #(
        .MASTER_KEY    (MASTER_KEY),
        .DUPLEX_ROUNDS (2)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .mem_rdata     (mem_rdata),
        .mem_req       (mem_req),
        .result        (result),
        .credit_return (credit_return)
    );

    tb_monitor #(
        .MASTER_KEY (MASTER_KEY)
    ) u_monitor (
        .clk           (clk),
        .pre_we        (pre_we),
        .pre_addr      (pre_addr),
        .pre_data      (pre_data),
        .ann_valid     (cmd_valid),
        .ann_cmd       (cmd),
        .ann_plain     (ann_plain),
        .mem_req       (mem_req),
        .result        (result),
        .credit_return (credit_return),
        .tests_run     (tests_run),
        .tests_failed  (tests_failed)
    );

    task automatic preload(input addr_t a, input word_t d);
        pre_we   = 1'b1;
        pre_addr = a;
        pre_data = d;
        @(negedge clk);
        pre_we = 1'b0;
    endtask

    task automatic fill_random(input addr_t base, input int n);
        for (int i = 0; i < n; i++)
            preload(base + addr_t'(2 * i), word_t'($urandom));
    endtask

    function automatic cmd_t make_cmd(input op_e op, input addr_t key_addr, input int n_ad,
                                      input addr_t body, input int n_body, input addr_t out);
        cmd_t c;
        c.op         = op;
        c.key_addr   = key_addr;
        c.ad_start   = AD_BASE;
        c.ad_end     = AD_BASE + addr_t'(2 * n_ad);
        c.body_start = body;
        c.body_end   = body + addr_t'(2 * n_body);
        c.out_start  = out;
        c.tag_addr   = TAG_BASE;
        return c;
    endfunction

    task automatic wait_credit(input string what);
        int n;
        n = 0;
        while (!timed_out && credits == 0)
        begin
            @(negedge clk);
            n++;
            if (n >= TIMEOUT)
            begin
                $display("timeout: no credit came back while waiting for %s", what);
                timed_out = 1'b1;
            end
        end
    endtask

    // plain points at the original plaintext or is zero
    task automatic run_cmd(input cmd_t c, input addr_t plain);
        if (timed_out)
            return;
        wait_credit("a free command slot");
        if (timed_out)
            return;
        cmd_valid = 1'b1;
        cmd       = c;
        ann_plain = plain;
        issued++;
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_credit("the result");
    endtask

    initial
    begin
        cmd_t  c;
        int    n_ad;
        int    n_body;
        addr_t key;
        int    chk_fails;
        void'($urandom(32'h7725f9ac));
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        pre_we    = 1'b0;
        pre_addr  = '0;
        pre_data  = '0;
        ann_plain = '0;
        issued    = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_random(AD_BASE, 3);
        fill_random(BODY_BASE, 5);
        run_cmd(make_cmd(OP_WRAP, '0, 3, BODY_BASE, 5, OUT_BASE), '0);
        run_cmd(make_cmd(OP_UNWRAP, '0, 3, OUT_BASE, 5, PLAIN_BASE), BODY_BASE);
        preload(TAG_BASE + addr_t'(2), mem[(TAG_BASE >> 1) + 1] ^ 16'h0100);
        run_cmd(make_cmd(OP_UNWRAP, '0, 3, OUT_BASE, 5, PLAIN_BASE), '0);

        fill_random(KEY_BASE, KEY_WORDS);
        run_cmd(make_cmd(OP_WRAP, KEY_BASE, 3, BODY_BASE, 5, OUT_BASE), '0);

        // bad ranges
        c = make_cmd(OP_WRAP, '0, 2, BODY_BASE, 2, OUT_BASE);
        c.ad_start = AD_BASE + addr_t'(1);
        run_cmd(c, '0);
        c = make_cmd(OP_WRAP, '0, 2, BODY_BASE, 2, OUT_BASE);
        c.body_end = BODY_BASE - addr_t'(2);
        run_cmd(c, '0);

        for (int i = 0; i < 20; i++)
        begin
            n_ad   = (i == 0) ? 0 : int'($urandom_range(8, 0));
            n_body = (i == 1) ? 0 : int'($urandom_range(8, 0));
            key    = ($urandom_range(1, 0) == 1) ? KEY_BASE : '0;
            if (key != '0)
                fill_random(KEY_BASE, KEY_WORDS);
            fill_random(AD_BASE, n_ad);
            fill_random(BODY_BASE, n_body);
            run_cmd(make_cmd(OP_WRAP, key, n_ad, BODY_BASE, n_body, OUT_BASE), '0);
            run_cmd(make_cmd(OP_UNWRAP, key, n_ad, OUT_BASE, n_body, PLAIN_BASE), BODY_BASE);
        end

        chk_fails = int'(DUT.u_wrap_sequencer.u_crypto_checker.fail_count);
        $display("%0d of %0d tests run, %0d failed, %0d assertion failures",
                 tests_run, issued, tests_failed, chk_fails);
        if (timed_out || tests_failed != 0 || chk_fails != 0 || tests_run != issued)
            $display("SOME TESTS FAILED");
        else
            $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim/tb_monitor.sv */
module tb_monitor
    import bus_pkg::*, crypto_pkg::*;
#(
    parameter logic [16*KEY_WORDS-1:0] MASTER_KEY = '0
)
(
    input  logic     clk,
    input  logic     pre_we,
    input  addr_t    pre_addr,
    input  word_t    pre_data,
    input  logic     ann_valid,
    input  cmd_t     ann_cmd,
    input  addr_t    ann_plain,
    input  mem_req_t mem_req,
    input  result_t  result,
    input  logic     credit_return,
    output int       tests_run,
    output int       tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t shadow [0:32767];
    addr_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_result;
    cmd_t  cur;
    addr_t plain;
    bit    bad;

    function automatic word_t rd(input addr_t a);
        return shadow[a[15:1]];
    endfunction

    // one absorb of the duplex
    function automatic word_t mix(input word_t s, input word_t d);
        word_t x;
        x = s ^ d;
        return word_t'((x << ROT) | (x >> (16 - ROT))) + ROUND_CONST;
    endfunction

    function automatic word_t predict(input cmd_t c);
        word_t s;
        word_t p;
        addr_t o;
        logic  ok;
        exp_addr.delete();
        exp_data.delete();
        if (c.key_addr[0] || c.ad_start[0] || c.ad_end[0] || c.body_start[0] ||
            c.body_end[0] || c.out_start[0] || c.tag_addr[0] ||
            c.ad_end < c.ad_start || c.body_end < c.body_start)
            return '0;
        s = '0;
        for (int i = 0; i < KEY_WORDS; i++)
            s = s ^ ((c.key_addr == '0) ? MASTER_KEY[16*i +: 16] :
                                          rd(c.key_addr + addr_t'(2 * i)));
        for (addr_t a = c.ad_start; a != c.ad_end; a = a + addr_t'(2))
            s = mix(s, rd(a));
        o = c.out_start;
        for (addr_t a = c.body_start; a != c.body_end; a = a + addr_t'(2))
        begin
            if (c.op == OP_WRAP)
            begin
                p = rd(a);
                exp_data.push_back(p ^ s);
            end
            else
            begin
                p = rd(a) ^ s;
                exp_data.push_back(p);
            end
            exp_addr.push_back(o);
            s = mix(s, p);
            o = o + addr_t'(2);
        end
        ok = 1'b1;
        for (int k = 0; k < TAG_WORDS && ok; k++)
        begin
            o = c.tag_addr + addr_t'(2 * k);
            if (c.op == OP_WRAP)
            begin
                exp_addr.push_back(o);
                exp_data.push_back(s);
            end
            else if (rd(o) != s)
                ok = 1'b0;
            s = mix(s, '0);
        end
        return (c.op == OP_WRAP) ? 16'd1 : word_t'(ok);
    endfunction

    task automatic check_write(input addr_t a, input word_t d);
        if (exp_addr.size() == 0)
        begin
            $display("unexpected memory write of %h to address %h at %0t", d, a, $time);
            bad = 1'b1;
        end
        else
        begin
            if (a !== exp_addr[0] || d !== exp_data[0])
            begin
                $display("[ERROR] %0t: wrote %h to %h, expected %h to %h",
                         $time, d, a, exp_data[0], exp_addr[0]);
                bad = 1'b1;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
        shadow[a[15:1]] = d;
    endtask

    task automatic finish_test();
        int len;
        if (result.value !== exp_result)
        begin
            $display("[ERROR] %0t: result %0d, expected %0d", $time, result.value, exp_result);
            bad = 1'b1;
        end
        if (exp_addr.size() != 0)
        begin
            $display("%0d expected memory writes never happened", exp_addr.size());
            bad = 1'b1;
        end
        // decrypted body against the original plaintext
        len = int'((cur.body_end - cur.body_start) >> 1);
        for (int i = 0; plain != '0 && i < len; i++)
        begin
            if (rd(cur.out_start + addr_t'(2 * i)) !== rd(plain + addr_t'(2 * i)))
            begin
                $display("[ERROR] %0t: round trip word %0d is %h, expected %h", $time, i,
                         rd(cur.out_start + addr_t'(2 * i)), rd(plain + addr_t'(2 * i)));
                bad = 1'b1;
            end
        end
        tests_run++;
        if (bad)
            tests_failed++;
        $display("test %0d %s result %0d: %s", tests_run,
                 (cur.op == OP_WRAP) ? "wrap" : "unwrap", result.value,
                 bad ? "failed" : "passed");
        bad = 1'b0;
    endtask

    always @(posedge clk)
    begin
        if (pre_we)
            shadow[pre_addr[15:1]] = pre_data;
        if (ann_valid)
        begin
            cur        = ann_cmd;
            plain      = ann_plain;
            exp_result = predict(ann_cmd);
        end
        if (mem_req.en && mem_req.wr)
            check_write(mem_req.addr, mem_req.wdata);
        // the credit comes back in the result cycle
        if (credit_return !== result.valid)
        begin
            $display("[ERROR] %0t: credit_return is %b while result.valid is %b",
                     $time, credit_return, result.valid);
            bad = 1'b1;
        end
        if (result.valid)
            finish_test();
    end

endmodule

/* sim/crypto_checker.sv */
module crypto_checker
    import bus_pkg::*, crypto_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  seq_state_e state,
    input  logic       cmd_start,
    input  logic       done,
    input  mem_req_t   mem_req
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    no_write_in_idle: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !(mem_req.en && mem_req.wr))
    else
    begin
        $error("memory write while the sequencer is idle");
        fail_count++;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else
    begin
        $error("done held for more than one cycle");
        fail_count++;
    end

    // a second command while busy shows up here
    start_only_idle: assert property (@(posedge clk) disable iff (reset)
        cmd_start |-> (state == IDLE))
    else
    begin
        $error("command start outside idle");
        fail_count++;
    end

endmodule

bind wrap_sequencer crypto_checker u_crypto_checker (.*);

/* src/crypto_top.sv */
module crypto_top
    import bus_pkg::*, crypto_pkg::*;
#(
    parameter logic [16*KEY_WORDS-1:0] MASTER_KEY    = 64'h3c6e_f372_a54f_f53a,
    parameter int                      DUPLEX_ROUNDS = 2
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cmd_valid,
    input  cmd_t     cmd,
    input  word_t    mem_rdata,
    output mem_req_t mem_req,
    output result_t  result,
    output logic     credit_return
);

    cmd_t     held;
    logic     cmd_start;
    logic     range_ok;
    logic     rd_load;
    addr_t    rd_base;
    addr_t    rd_limit;
    logic     rd_step;
    logic     out_load;
    addr_t    out_base;
    logic     out_step;
    addr_t    rd_addr;
    addr_t    out_addr;
    logic     rd_done;
    logic     dup_init;
    key_sel_e dup_key_sel;
    logic     dup_key_word_load;
    logic     dup_absorb;
    logic     dup_squeeze;
    logic     dup_unwrap;
    word_t    dup_din;
    logic     dup_busy;
    word_t    dup_dout;
    logic     done;
    logic     pass;

    cmd_decode u_cmd_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .held      (held),
        .cmd_start (cmd_start),
        .range_ok  (range_ok)
    );

    addr_gen u_addr_gen (
        .clk      (clk),
        .rd_load  (rd_load),
        .rd_base  (rd_base),
        .rd_limit (rd_limit),
        .rd_step  (rd_step),
        .out_load (out_load),
        .out_base (out_base),
        .out_step (out_step),
        .rd_addr  (rd_addr),
        .out_addr (out_addr),
        .rd_done  (rd_done)
    );

    duplex_core #(
        .MASTER_KEY    (MASTER_KEY),
        .DUPLEX_ROUNDS (DUPLEX_ROUNDS)
    ) u_duplex_core (
        .clk           (clk),
        .reset         (reset),
        .init          (dup_init),
        .key_sel       (dup_key_sel),
        .key_word_load (dup_key_word_load),
        .absorb        (dup_absorb),
        .unwrap        (dup_unwrap),
        .squeeze       (dup_squeeze),
        .din           (dup_din),
        .busy          (dup_busy),
        .dout          (dup_dout)
    );

    wrap_sequencer u_wrap_sequencer (
        .clk               (clk),
        .reset             (reset),
        .cmd               (held),
        .cmd_start         (cmd_start),
        .range_ok          (range_ok),
        .rd_done           (rd_done),
        .rd_addr           (rd_addr),
        .out_addr          (out_addr),
        .dup_busy          (dup_busy),
        .dup_dout          (dup_dout),
        .mem_rdata         (mem_rdata),
        .rd_load           (rd_load),
        .rd_base           (rd_base),
        .rd_limit          (rd_limit),
        .rd_step           (rd_step),
        .out_load          (out_load),
        .out_base          (out_base),
        .out_step          (out_step),
        .dup_init          (dup_init),
        .dup_key_sel       (dup_key_sel),
        .dup_key_word_load (dup_key_word_load),
        .dup_absorb        (dup_absorb),
        .dup_squeeze       (dup_squeeze),
        .dup_unwrap        (dup_unwrap),
        .dup_din           (dup_din),
        .mem_req           (mem_req),
        .done              (done),
        .pass              (pass)
    );

    result_unit u_result_unit (
        .clk           (clk),
        .reset         (reset),
        .done          (done),
        .pass          (pass),
        .result        (result),
        .credit_return (credit_return)
    );

endmodule

/* src/result_unit.sv */
module result_unit
    import bus_pkg::*, crypto_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    done,
    input  logic    pass,
    output result_t result,
    output logic    credit_return
);

    // value only matters while valid is high
    always_ff @(posedge clk)
    begin
        if (done)
            result.value <= word_t'(pass);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result.valid  <= 1'b0;
            credit_return <= 1'b0;
        end
        else
        begin
            result.valid  <= done;
            // one command slot, so every result frees the host credit
            credit_return <= done;
        end
    end

endmodule

/* src/wrap_sequencer.sv */
module wrap_sequencer
    import bus_pkg::*, crypto_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  cmd_t     cmd,
    input  logic     cmd_start,
    input  logic     range_ok,
    input  logic     rd_done,
    input  addr_t    rd_addr,
    input  addr_t    out_addr,
    input  logic     dup_busy,
    input  word_t    dup_dout,
    input  word_t    mem_rdata,
    output logic     rd_load,
    output addr_t    rd_base,
    output addr_t    rd_limit,
    output logic     rd_step,
    output logic     out_load,
    output addr_t    out_base,
    output logic     out_step,
    output logic     dup_init,
    output key_sel_e dup_key_sel,
    output logic     dup_key_word_load,
    output logic     dup_absorb,
    output logic     dup_squeeze,
    output logic     dup_unwrap,
    output word_t    dup_din,
    output mem_req_t mem_req,
    output logic     done,
    output logic     pass
);

    seq_state_e state;
    seq_state_e next_state;
    logic       pend;
    logic       pass_q;
    logic       rd_issue;
    logic       mismatch;

    always_comb
    begin
        next_state        = state;
        rd_issue          = 1'b0;
        mismatch          = 1'b0;
        done              = 1'b0;
        rd_load           = 1'b0;
        rd_base           = '0;
        rd_limit          = '0;
        rd_step           = 1'b0;
        out_load          = 1'b0;
        out_base          = '0;
        out_step          = 1'b0;
        dup_init          = 1'b0;
        dup_key_sel       = KEY_NONE;
        dup_key_word_load = 1'b0;
        dup_absorb        = 1'b0;
        dup_squeeze       = 1'b0;
        dup_unwrap        = 1'b0;
        dup_din           = mem_rdata;
        mem_req           = '0;
        mem_req.addr      = rd_addr;
        mem_req.wdata     = dup_dout;

        case (state)
            IDLE:
                if (cmd_start)
                    next_state = CHECK;
            CHECK:
            begin
                if (!range_ok)
                begin
                    done       = 1'b1;
                    next_state = IDLE;
                end
                else if (cmd.key_addr != '0)
                begin
                    rd_load    = 1'b1;
                    rd_base    = cmd.key_addr;
                    rd_limit   = cmd.key_addr + addr_t'(2 * KEY_WORDS);
                    next_state = LOAD_KEY;
                end
                else
                    next_state = KEY_INIT;
            end
            LOAD_KEY:
            begin
                dup_key_word_load = pend;
                if (rd_done)
                    next_state = KEY_INIT;
                else
                    rd_issue = 1'b1;
            end
            KEY_INIT:
            begin
                dup_init    = 1'b1;
                dup_key_sel = (cmd.key_addr != '0) ? KEY_MEM : KEY_MASTER;
                rd_load     = 1'b1;
                rd_base     = cmd.ad_start;
                rd_limit    = cmd.ad_end;
                next_state  = AD_READ;
            end
            AD_READ:
            begin
                if (rd_done)
                begin
                    rd_load    = 1'b1;
                    rd_base    = cmd.body_start;
                    rd_limit   = cmd.body_end;
                    out_load   = 1'b1;
                    out_base   = cmd.out_start;
                    next_state = BODY_READ;
                end
                else
                begin
                    rd_issue   = 1'b1;
                    next_state = AD_WAIT;
                end
            end
            AD_WAIT:
            begin
                if (pend)
                    dup_absorb = 1'b1;
                else if (!dup_busy)
                    next_state = AD_READ;
            end
            BODY_READ:
            begin
                if (rd_done)
                    next_state = TAG_INIT;
                else
                begin
                    rd_issue   = 1'b1;
                    next_state = BODY_WAIT;
                end
            end
            BODY_WAIT:
            begin
                if (pend)
                begin
                    dup_absorb = 1'b1;
                    dup_unwrap = (cmd.op == OP_UNWRAP);
                end
                else if (!dup_busy)
                begin
                    mem_req.en   = 1'b1;
                    mem_req.wr   = 1'b1;
                    mem_req.addr = out_addr;
                    out_step     = 1'b1;
                    next_state   = BODY_READ;
                end
            end
            TAG_INIT:
            begin
                rd_load    = 1'b1;
                rd_base    = cmd.tag_addr;
                rd_limit   = cmd.tag_addr + addr_t'(2 * TAG_WORDS);
                out_load   = 1'b1;
                out_base   = cmd.tag_addr;
                next_state = TAG_STEP;
            end
            TAG_STEP:
            begin
                // unwrap fetches the stored tag word alongside the squeeze
                dup_squeeze = 1'b1;
                rd_step     = 1'b1;
                mem_req.en  = (cmd.op == OP_UNWRAP);
                next_state  = TAG_WAIT;
            end
            TAG_WAIT:
            begin
                if (pend)
                begin
                    if (cmd.op == OP_WRAP)
                    begin
                        mem_req.en   = 1'b1;
                        mem_req.wr   = 1'b1;
                        mem_req.addr = out_addr;
                        out_step     = 1'b1;
                    end
                    else if (mem_rdata != dup_dout)
                    begin
                        mismatch   = 1'b1;
                        next_state = FINISH;
                    end
                end
                else if (!dup_busy)
                    next_state = rd_done ? FINISH : TAG_STEP;
            end
            FINISH:
            begin
                done       = 1'b1;
                next_state = IDLE;
            end
            default:
                next_state = IDLE;
        endcase

        if (rd_issue)
        begin
            mem_req.en = 1'b1;
            rd_step    = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= IDLE;
            pend   <= 1'b0;
            pass_q <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // data or squeezed word lands next cycle
            pend  <= rd_issue || dup_squeeze;
            if (state == CHECK)
                pass_q <= 1'b1;
            else if (mismatch)
                pass_q <= 1'b0;
        end
    end

    assign pass = (state == FINISH) && pass_q;

endmodule

/* src/duplex_core.sv */
module duplex_core
    import crypto_pkg::*;
#(
    parameter logic [16*KEY_WORDS-1:0] MASTER_KEY    = '0,
    parameter int                      DUPLEX_ROUNDS = 2
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        init,
    input  key_sel_e    key_sel,
    input  logic        key_word_load,
    input  logic        absorb,
    input  logic        unwrap,
    input  logic        squeeze,
    input  logic [15:0] din,
    output logic        busy,
    output logic [15:0] dout
);

    localparam int CW = $clog2(DUPLEX_ROUNDS + 1);

    logic [15:0]             s;
    logic [16*KEY_WORDS-1:0] key_sr;
    logic [CW-1:0]           round_cnt;
    logic [15:0]             in_word;

    function automatic logic [15:0] fold_key(input logic [16*KEY_WORDS-1:0] k);
        logic [15:0] acc;
        acc = '0;
        for (int i = 0; i < KEY_WORDS; i++)
            acc = acc ^ k[16*i +: 16];
        return acc;
    endfunction

    // squeeze absorbs zero, decryption absorbs the recovered plaintext
    assign in_word = squeeze ? 16'h0000 : (unwrap ? (din ^ s) : din);

    always_ff @(posedge clk)
    begin
        if (key_word_load)
            key_sr <= {key_sr[16*KEY_WORDS-17:0], din};

        if (init)
        begin
            case (key_sel)
                KEY_MASTER: s <= fold_key(MASTER_KEY);
                KEY_MEM:    s <= fold_key(key_sr);
                default:    s <= '0;
            endcase
        end
        else if (absorb || squeeze)
        begin
            s    <= s ^ in_word;
            dout <= squeeze ? s : (din ^ s);
        end
        else if (round_cnt == CW'(1))
            s <= {s[15-ROT:0], s[15:16-ROT]} + ROUND_CONST;
    end

    // permutation lands on the last busy cycle
    always_ff @(posedge clk)
    begin
        if (reset || init)
            round_cnt <= '0;
        else if (absorb || squeeze)
            round_cnt <= CW'(DUPLEX_ROUNDS);
        else if (round_cnt != '0)
            round_cnt <= round_cnt - 1'b1;
    end

    assign busy = (round_cnt != '0);

endmodule

/* src/addr_gen.sv */
module addr_gen
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rd_load,
    input  addr_t rd_base,
    input  addr_t rd_limit,
    input  logic  rd_step,
    input  logic  out_load,
    input  addr_t out_base,
    input  logic  out_step,
    output addr_t rd_addr,
    output addr_t out_addr,
    output logic  rd_done
);

    addr_t rd_ctr;
    addr_t rd_lim;
    addr_t out_ctr;

    // read side, counter and limit load together
    always_ff @(posedge clk)
    begin
        if (rd_load)
        begin
            rd_ctr <= rd_base;
            rd_lim <= rd_limit;
        end
        else if (rd_step)
            rd_ctr <= rd_ctr + addr_t'(2);
    end

    // output side walks body output and then the tag
    always_ff @(posedge clk)
    begin
        if (out_load)
            out_ctr <= out_base;
        else if (out_step)
            out_ctr <= out_ctr + addr_t'(2);
    end

    assign rd_addr  = rd_ctr;
    assign out_addr = out_ctr;

    // equality so that a range ending at the top of memory still terminates
    assign rd_done = (rd_ctr == rd_lim);

endmodule

/* src/cmd_decode.sv */
module cmd_decode
    import bus_pkg::*, crypto_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic cmd_valid,
    input  cmd_t cmd,
    output cmd_t held,
    output logic cmd_start,
    output logic range_ok
);

    logic addr_even;
    logic order_ok;

    function automatic logic is_even(input addr_t a);
        return (a[0] == 1'b0);
    endfunction

    assign addr_even = is_even(cmd.key_addr) && is_even(cmd.ad_start) &&
                       is_even(cmd.ad_end) && is_even(cmd.body_start) &&
                       is_even(cmd.body_end) && is_even(cmd.out_start) &&
                       is_even(cmd.tag_addr);

    // an empty range has end equal to start
    assign order_ok = (cmd.ad_end >= cmd.ad_start) &&
                      (cmd.body_end >= cmd.body_start);

    always_ff @(posedge clk)
    begin
        if (cmd_valid)
        begin
            held     <= cmd;
            range_ok <= addr_even && order_ok;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            cmd_start <= 1'b0;
        else
            cmd_start <= cmd_valid;
    end

endmodule

/* src/crypto_pkg.sv */
package crypto_pkg;

    import bus_pkg::*;

    typedef enum logic {
        OP_WRAP,
        OP_UNWRAP
    } op_e;

    typedef enum logic [1:0] {
        KEY_NONE,
        KEY_MASTER,
        KEY_MEM
    } key_sel_e;

    typedef enum logic [3:0] {
        IDLE,
        CHECK,
        LOAD_KEY,
        KEY_INIT,
        AD_READ,
        AD_WAIT,
        BODY_READ,
        BODY_WAIT,
        TAG_INIT,
        TAG_STEP,
        TAG_WAIT,
        FINISH
    } seq_state_e;

    // key_addr of zero selects the master key
    typedef struct packed {
        op_e   op;
        addr_t key_addr;
        addr_t ad_start;
        addr_t ad_end;
        addr_t body_start;
        addr_t body_end;
        addr_t out_start;
        addr_t tag_addr;
    } cmd_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } result_t;

    // duplex constants
    localparam int          KEY_WORDS   = 4;
    localparam int          TAG_WORDS   = 2;
    localparam logic [15:0] ROUND_CONST = 16'h9e37;
    localparam int          ROT         = 3;

endpackage

/* src/bus_pkg.sv */
package bus_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 16;

    // data word on the memory bus
    typedef logic [WORD_W-1:0] word_t;

    // byte address, words sit at even addresses
    typedef logic [ADDR_W-1:0] addr_t;

    // one request per cycle, a read answers on the next cycle
    typedef struct packed {
        logic  en;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage
